// ==== hdl/soc_mem_pkg.sv ====
// address window bits, instruction cache geometry, pwm register map and widths
package soc_mem_pkg;

    // data address window bits
    localparam int mem_win_bit   = 30; // main memory
    localparam int per_win_bit   = 29; // peripherals, only while timer bit is clear
    localparam int timer_win_bit = 28; // free-running timer

    // instruction cache, one 32-bit word per line
    localparam int ic_lines   = 16;
    localparam int ic_index_w = 4;  // fetch address bits 5:2
    localparam int ic_tag_w   = 26; // fetch address bits 31:6

    // pwm
    localparam int pwm_w = 16; // period, duty and counter width

    localparam logic [3:0] pwm_period_off = 4'h0;
    localparam logic [3:0] pwm_duty0_off  = 4'h4;
    localparam logic [3:0] pwm_duty1_off  = 4'h8;

endpackage

// ==== hdl/instr_cache.sv ====
// direct-mapped instruction cache, one word per line, with refill request
`timescale 1ns/1ps

module instr_cache (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic [31:0] fetch_addr_i,
    output logic [31:0] instr_o,
    output logic        instr_wait_o,

    output logic        refill_req_o,
    output logic [31:0] refill_addr_o,
    input  logic        refill_done_i,
    input  logic [31:0] refill_data_i
);

    logic [soc_mem_pkg::ic_index_w-1:0] fetch_idx;
    logic [soc_mem_pkg::ic_tag_w-1:0]   fetch_tag;
    logic [soc_mem_pkg::ic_index_w-1:0] fill_idx;
    logic [soc_mem_pkg::ic_tag_w-1:0]   fill_tag;

    logic [soc_mem_pkg::ic_lines-1:0]   valid_q;
    logic [soc_mem_pkg::ic_tag_w-1:0]   tag_mem  [soc_mem_pkg::ic_lines];
    logic [31:0]                        data_mem [soc_mem_pkg::ic_lines];

    logic        hit;
    logic        refill_req_q;
    logic [31:0] refill_addr_q;

    assign fetch_idx = fetch_addr_i[2 +: soc_mem_pkg::ic_index_w];
    assign fetch_tag = fetch_addr_i[31 -: soc_mem_pkg::ic_tag_w];
    assign fill_idx  = refill_addr_q[2 +: soc_mem_pkg::ic_index_w];
    assign fill_tag  = refill_addr_q[31 -: soc_mem_pkg::ic_tag_w];

    assign hit          = valid_q[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
    assign instr_o      = data_mem[fetch_idx];
    assign instr_wait_o = !hit;

    assign refill_req_o  = refill_req_q;
    assign refill_addr_o = refill_addr_q;

    // request and valid bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q      <= '0;
            refill_req_q <= 1'b0;
        end else begin
            if (refill_done_i) begin
                valid_q[fill_idx] <= 1'b1;
                refill_req_q      <= 1'b0; // line is a hit next cycle
            end else if (!refill_req_q && !hit) begin
                refill_req_q <= 1'b1;
            end
        end
    end

    // refill address and line arrays
    always_ff @(posedge clk_i) begin
        if (!refill_req_q && !hit) begin
            refill_addr_q <= {fetch_addr_i[31:2], 2'b00}; // word aligned
        end
        if (refill_done_i) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= refill_data_i;
        end
    end

    a_refill_addr_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        refill_req_o && !refill_done_i |=> $stable(refill_addr_o)
    ) else $error("refill address changed while request held");

endmodule

// ==== hdl/mem_controller.sv ====
// iomem arbiter for cache refill and data ports, plus free-running timer
`timescale 1ns/1ps

module mem_controller (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        refill_req_i,
    input  logic [31:0] refill_addr_i,
    output logic        refill_done_o,
    output logic [31:0] refill_data_o,

    input  logic        data_req_i,
    input  logic [31:0] data_addr_i,
    input  logic [31:0] data_wdata_i,
    input  logic [3:0]  data_mask_i,
    input  logic        data_we_i,
    output logic        data_stall_o,
    output logic [31:0] data_rdata_o,

    output logic [31:0] timer_o,

    output logic        iomem_valid_o,
    output logic [3:0]  iomem_wstrb_o,
    output logic [31:0] iomem_addr_o,
    output logic [31:0] iomem_wdata_o,
    input  logic        iomem_ready_i,
    input  logic [31:0] iomem_rdata_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_refill,
        st_data
    } grant_state_t;

    grant_state_t state_q;

    logic        iomem_valid_q;
    logic [3:0]  iomem_wstrb_q;
    logic [31:0] iomem_addr_q;
    logic [31:0] iomem_wdata_q;
    logic [31:0] rdata_q;
    logic        refill_done_q;
    logic        data_ack_q;
    logic [31:0] timer_q;

    logic        grant_data;
    logic        grant_refill;
    logic        bus_done;

    // data wins when both are pending, ack cycles are not requests
    assign grant_data   = (state_q == st_idle) && data_req_i && !data_ack_q;
    assign grant_refill = (state_q == st_idle) && !grant_data
                          && refill_req_i && !refill_done_q;
    assign bus_done     = iomem_valid_q && iomem_ready_i;

    assign iomem_valid_o = iomem_valid_q;
    assign iomem_wstrb_o = iomem_wstrb_q;
    assign iomem_addr_o  = iomem_addr_q;
    assign iomem_wdata_o = iomem_wdata_q;

    assign refill_done_o = refill_done_q;
    assign refill_data_o = rdata_q;
    assign data_stall_o  = data_req_i && !data_ack_q;
    assign data_rdata_o  = rdata_q;
    assign timer_o       = timer_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= st_idle;
            iomem_valid_q <= 1'b0;
            refill_done_q <= 1'b0;
            data_ack_q    <= 1'b0;
            timer_q       <= '0;
        end else begin
            timer_q       <= timer_q + 32'd1;
            refill_done_q <= 1'b0; // one-cycle pulses
            data_ack_q    <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (grant_data) begin
                        state_q       <= st_data;
                        iomem_valid_q <= 1'b1;
                    end else if (grant_refill) begin
                        state_q       <= st_refill;
                        iomem_valid_q <= 1'b1;
                    end
                end
                st_refill: begin
                    if (bus_done) begin
                        state_q       <= st_idle;
                        iomem_valid_q <= 1'b0;
                        refill_done_q <= 1'b1;
                    end
                end
                st_data: begin
                    if (bus_done) begin
                        state_q       <= st_idle;
                        iomem_valid_q <= 1'b0;
                        data_ack_q    <= 1'b1;
                    end
                end
                default: begin
                    state_q       <= st_idle;
                    iomem_valid_q <= 1'b0;
                end
            endcase
        end
    end

    // bus fields and response word
    always_ff @(posedge clk_i) begin
        if (grant_data) begin
            iomem_addr_q  <= data_addr_i;
            iomem_wstrb_q <= data_we_i ? data_mask_i : 4'b0000; // zero strobe is a read
            iomem_wdata_q <= data_wdata_i;
        end else if (grant_refill) begin
            iomem_addr_q  <= refill_addr_i;
            iomem_wstrb_q <= 4'b0000;
            iomem_wdata_q <= '0;
        end
        if (bus_done) begin
            rdata_q <= iomem_rdata_i;
        end
    end

    a_iomem_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        iomem_valid_o && !iomem_ready_i |=> iomem_valid_o
            && $stable(iomem_addr_o) && $stable(iomem_wstrb_o) && $stable(iomem_wdata_o)
    ) else $error("iomem fields changed before ready");

    a_one_response: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(refill_done_o && data_req_i && data_ack_q)
    ) else $error("refill and data responses in the same cycle");

endmodule

// ==== hdl/pwm_regs.sv ====
// pwm period and duty registers, byte-masked writes and read back
`timescale 1ns/1ps

module pwm_regs (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         wr_i,
    input  logic                         sel_i,
    input  logic [3:0]                   addr_i,
    input  logic [31:0]                  wdata_i,
    input  logic [3:0]                   mask_i,
    output logic [31:0]                  rdata_o,

    output logic [soc_mem_pkg::pwm_w-1:0] period_o,
    output logic [soc_mem_pkg::pwm_w-1:0] duty0_o,
    output logic [soc_mem_pkg::pwm_w-1:0] duty1_o
);

    logic [soc_mem_pkg::pwm_w-1:0] period_q;
    logic [soc_mem_pkg::pwm_w-1:0] duty0_q;
    logic [soc_mem_pkg::pwm_w-1:0] duty1_q;
    logic                          wr_en;

    // only the byte lanes that exist in a register take effect
    function automatic logic [soc_mem_pkg::pwm_w-1:0] merge_bytes(
        input logic [soc_mem_pkg::pwm_w-1:0] cur,
        input logic [31:0]                   wd,
        input logic [3:0]                    m
    );
        logic [soc_mem_pkg::pwm_w-1:0] res;
        res = cur;
        for (int b = 0; b < soc_mem_pkg::pwm_w / 8; b++) begin
            if (m[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en    = sel_i && wr_i;
    assign period_o = period_q;
    assign duty0_o  = duty0_q;
    assign duty1_o  = duty1_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            period_q <= '0;
            duty0_q  <= '0;
            duty1_q  <= '0;
        end else if (wr_en) begin
            case (addr_i)
                soc_mem_pkg::pwm_period_off: period_q <= merge_bytes(period_q, wdata_i, mask_i);
                soc_mem_pkg::pwm_duty0_off:  duty0_q  <= merge_bytes(duty0_q, wdata_i, mask_i);
                soc_mem_pkg::pwm_duty1_off:  duty1_q  <= merge_bytes(duty1_q, wdata_i, mask_i);
                default: ; // unmapped offset ignored
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            soc_mem_pkg::pwm_period_off: rdata_o = 32'(period_q);
            soc_mem_pkg::pwm_duty0_off:  rdata_o = 32'(duty0_q);
            soc_mem_pkg::pwm_duty1_off:  rdata_o = 32'(duty1_q);
            default:                     rdata_o = '0;
        endcase
    end

endmodule

// ==== hdl/pwm_gen.sv ====
// two pwm channels on one shared period counter
`timescale 1ns/1ps

module pwm_gen (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic [soc_mem_pkg::pwm_w-1:0] period_i,
    input  logic [soc_mem_pkg::pwm_w-1:0] duty0_i,
    input  logic [soc_mem_pkg::pwm_w-1:0] duty1_i,

    output logic                          pwm0_o,
    output logic                          pwm1_o
);

    logic [soc_mem_pkg::pwm_w-1:0] cnt_q;
    logic                          pwm0_q;
    logic                          pwm1_q;

    assign pwm0_o = pwm0_q;
    assign pwm1_o = pwm1_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q  <= '0;
            pwm0_q <= 1'b0;
            pwm1_q <= 1'b0;
        end else begin
            if (cnt_q >= period_i) begin
                cnt_q <= '0; // also recovers when period shrinks
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            pwm0_q <= (cnt_q < duty0_i);
            pwm1_q <= (cnt_q < duty1_i);
        end
    end

endmodule

// ==== hdl/soc_mem_top.sv ====
// memory and i/o subsystem top, data window decode, response muxing, instances
`timescale 1ns/1ps

module soc_mem_top (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic [31:0] fetch_addr_i,
    output logic [31:0] instr_o,
    output logic        instr_wait_o,

    input  logic        data_sel_i,
    input  logic [31:0] data_addr_i,
    input  logic [31:0] data_wdata_i,
    input  logic [3:0]  data_mask_i,
    input  logic        data_we_i,
    output logic        data_stall_o,
    output logic [31:0] data_rdata_o,

    output logic        iomem_valid_o,
    input  logic        iomem_ready_i,
    output logic [3:0]  iomem_wstrb_o,
    output logic [31:0] iomem_addr_o,
    output logic [31:0] iomem_wdata_o,
    input  logic [31:0] iomem_rdata_i,

    output logic        pwm0_o,
    output logic        pwm1_o
);

    logic        refill_req;
    logic [31:0] refill_addr;
    logic        refill_done;
    logic [31:0] refill_data;

    logic        mem_sel;
    logic        mem_stall;
    logic [31:0] mem_rdata;
    logic [31:0] timer_val;

    logic        per_sel;
    logic [31:0] per_rdata;

    logic [soc_mem_pkg::pwm_w-1:0] pwm_period;
    logic [soc_mem_pkg::pwm_w-1:0] pwm_duty0;
    logic [soc_mem_pkg::pwm_w-1:0] pwm_duty1;

    assign mem_sel = data_sel_i && data_addr_i[soc_mem_pkg::mem_win_bit];
    assign per_sel = data_sel_i && data_addr_i[soc_mem_pkg::per_win_bit]
                     && !data_addr_i[soc_mem_pkg::timer_win_bit];

    // memory first, then timer, then peripherals; only memory stalls
    assign data_stall_o = data_addr_i[soc_mem_pkg::mem_win_bit] ? mem_stall : 1'b0;
    assign data_rdata_o = data_addr_i[soc_mem_pkg::mem_win_bit]   ? mem_rdata :
                          data_addr_i[soc_mem_pkg::timer_win_bit] ? timer_val :
                                                                    per_rdata;

    instr_cache u_icache (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_addr_i  (fetch_addr_i),
        .instr_o       (instr_o),
        .instr_wait_o  (instr_wait_o),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_done_i (refill_done),
        .refill_data_i (refill_data)
    );

    mem_controller u_memctl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_done_o (refill_done),
        .refill_data_o (refill_data),
        .data_req_i    (mem_sel),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_mask_i   (data_mask_i),
        .data_we_i     (data_we_i),
        .data_stall_o  (mem_stall),
        .data_rdata_o  (mem_rdata),
        .timer_o       (timer_val),
        .iomem_valid_o (iomem_valid_o),
        .iomem_wstrb_o (iomem_wstrb_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_wdata_o (iomem_wdata_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i)
    );

    pwm_regs u_pwm_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_i     (data_we_i),
        .sel_i    (per_sel),
        .addr_i   (data_addr_i[3:0]),
        .wdata_i  (data_wdata_i),
        .mask_i   (data_mask_i),
        .rdata_o  (per_rdata),
        .period_o (pwm_period),
        .duty0_o  (pwm_duty0),
        .duty1_o  (pwm_duty1)
    );

    pwm_gen u_pwm_gen (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .period_i (pwm_period),
        .duty0_i  (pwm_duty0),
        .duty1_i  (pwm_duty1),
        .pwm0_o   (pwm0_o),
        .pwm1_o   (pwm1_o)
    );

endmodule

// ==== dv/iomem_model.sv ====
// iomem memory responder with random ready delay and byte-strobe writes
`timescale 1ns/1ps

module iomem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic [3:0]  wstrb_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic        ready_o,
    output logic [31:0] rdata_o
);

    logic [31:0] mem [256];
    bit          written [256];
    logic [31:0] lfsr_q   = 32'h61cd_bd49;
    logic [1:0]  wait_cnt = 2'd0;
    logic        ready_q  = 1'b0;
    logic [31:0] rdata_q  = 32'h0;

    assign ready_o = ready_q;
    assign rdata_o = rdata_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two lfsr steps, one per delay bit
    task automatic draw_delay();
        wait_cnt[0] = lfsr_q[0];
        lfsr_q      = lfsr_next(lfsr_q);
        wait_cnt[1] = lfsr_q[0];
        lfsr_q      = lfsr_next(lfsr_q);
    endtask

    always @(posedge clk_i) begin
        logic [7:0]  idx;
        logic [31:0] word;
        logic [31:0] lanes;
        idx   = addr_i[9:2];
        word  = written[idx] ? mem[idx] : ~{2'b00, addr_i[31:2]}; // fill is inverted word address
        lanes = {{8{wstrb_i[3]}}, {8{wstrb_i[2]}}, {8{wstrb_i[1]}}, {8{wstrb_i[0]}}};
        if (rst_i) begin
            ready_q <= 1'b0;
            written = '{default: 1'b0};
            draw_delay();
        end else if (ready_q) begin
            ready_q <= 1'b0; // handshake taken at this edge
            draw_delay();
        end else if (valid_i) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt = wait_cnt - 2'd1;
            end else begin
                word = (word & ~lanes) | (wdata_i & lanes);
                if (wstrb_i != 4'b0000) begin
                    mem[idx]     = word;
                    written[idx] = 1'b1;
                end
                rdata_q <= word;
                ready_q <= 1'b1;
            end
        end
    end

endmodule

// ==== dv/tb_soc_mem.sv ====
// testbench top with clock, reset, core-side fetch and data stimulus, checking assertions
`timescale 1ns/1ps

module tb_soc_mem;

    localparam int timeout_cycles = 200;
    localparam int timer_gap      = 7;

    logic        clk         = 1'b0;
    logic        rst         = 1'b1;
    logic [31:0] fetch_addr  = 32'h0;
    logic        data_sel    = 1'b0;
    logic [31:0] data_addr   = 32'h0;
    logic [31:0] data_wdata  = 32'h0;
    logic [3:0]  data_mask   = 4'h0;
    logic        data_we     = 1'b0;
    logic        pwm_written = 1'b0;

    logic [31:0] instr;
    logic        instr_wait;
    logic        data_stall;
    logic [31:0] data_rdata;
    logic        iomem_valid;
    logic        iomem_ready;
    logic [3:0]  iomem_wstrb;
    logic [31:0] iomem_addr;
    logic [31:0] iomem_wdata;
    logic [31:0] iomem_rdata;
    logic        pwm0;
    logic        pwm1;

    logic [31:0] mem_copy [256];
    bit          mem_set  [256];
    logic [soc_mem_pkg::pwm_w-1:0] period_copy = '0;
    logic [soc_mem_pkg::pwm_w-1:0] duty0_copy  = '0;
    logic [soc_mem_pkg::pwm_w-1:0] duty1_copy  = '0;

    always #20 clk = ~clk;

    soc_mem_top dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .fetch_addr_i  (fetch_addr),
        .instr_o       (instr),
        .instr_wait_o  (instr_wait),
        .data_sel_i    (data_sel),
        .data_addr_i   (data_addr),
        .data_wdata_i  (data_wdata),
        .data_mask_i   (data_mask),
        .data_we_i     (data_we),
        .data_stall_o  (data_stall),
        .data_rdata_o  (data_rdata),
        .iomem_valid_o (iomem_valid),
        .iomem_ready_i (iomem_ready),
        .iomem_wstrb_o (iomem_wstrb),
        .iomem_addr_o  (iomem_addr),
        .iomem_wdata_o (iomem_wdata),
        .iomem_rdata_i (iomem_rdata),
        .pwm0_o        (pwm0),
        .pwm1_o        (pwm1)
    );

    iomem_model u_mem (
        .clk_i   (clk),
        .rst_i   (rst),
        .valid_i (iomem_valid),
        .wstrb_i (iomem_wstrb),
        .addr_i  (iomem_addr),
        .wdata_i (iomem_wdata),
        .ready_o (iomem_ready),
        .rdata_o (iomem_rdata)
    );

    task automatic give_up(input string what);
        $display("Regression failed");
        $fatal(1, "%s", what);
    endtask

    task automatic report_mismatch(input string what);
        $display("CHECK FAILED at time %0t: %s", $time, what);
        give_up(what);
    endtask

    a_bus_stable: assert property (
        @(posedge clk) disable iff (rst)
        iomem_valid && !iomem_ready |=> iomem_valid && $stable(iomem_addr)
            && $stable(iomem_wstrb) && $stable(iomem_wdata)
    ) else report_mismatch("iomem fields moved while waiting for ready");

    a_bus_needs_request: assert property (
        @(posedge clk) disable iff (rst)
        iomem_valid |-> $past(instr_wait
            || (data_sel && data_addr[soc_mem_pkg::mem_win_bit]))
    ) else report_mismatch("iomem transaction without a pending request");

    a_pwm_idle: assert property (
        @(posedge clk) disable iff (rst)
        !pwm_written |-> !pwm0 && !pwm1
    ) else report_mismatch("pwm output active before configuration");

    function automatic logic [31:0] expected_fill(input logic [31:0] addr);
        return ~(addr >> 2);
    endfunction

    function automatic logic [31:0] expected_mem(input logic [31:0] addr);
        return mem_set[addr[9:2]] ? mem_copy[addr[9:2]] : expected_fill(addr);
    endfunction

    function automatic logic [31:0] masked_merge(input logic [31:0] old, input logic [31:0] wd,
                                                 input logic [3:0] mask);
        logic [31:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~lanes) | (wd & lanes);
    endfunction

    function automatic logic [31:0] expected_reg(input logic [3:0] off);
        case (off)
            soc_mem_pkg::pwm_period_off: return 32'(period_copy);
            soc_mem_pkg::pwm_duty0_off:  return 32'(duty0_copy);
            soc_mem_pkg::pwm_duty1_off:  return 32'(duty1_copy);
            default:                     return 32'h0;
        endcase
    endfunction

    task automatic apply_reset();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!iomem_valid && !pwm0 && !pwm1)
            else report_mismatch("bus or pwm active right after reset");
    endtask

    task automatic fetch_word(input logic [31:0] addr, input logic expect_hit);
        int cycles;
        @(posedge clk);
        fetch_addr <= addr;
        @(negedge clk);
        assert (instr_wait == !expect_hit)
            else report_mismatch($sformatf("fetch %h hit=%0b expected %0b", addr, !instr_wait,
                                           expect_hit));
        cycles = 0;
        while (instr_wait) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) give_up("instruction fetch never finished");
        end
        assert (instr == expected_fill(addr))
            else report_mismatch($sformatf("fetch %h got %h", addr, instr));
    endtask

    task automatic data_access(input logic [31:0] addr, input logic we, input logic [3:0] mask,
                               input logic [31:0] wdata, input logic no_stall,
                               output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        data_sel   <= 1'b1;
        data_addr  <= addr;
        data_we    <= we;
        data_mask  <= mask;
        data_wdata <= wdata;
        @(negedge clk);
        assert (!(no_stall && data_stall))
            else report_mismatch($sformatf("stall on access to %h", addr));
        cycles = 0;
        while (data_stall) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) give_up("data access never finished");
        end
        rdata = data_rdata; // completes at the next edge
        @(posedge clk);
        data_sel <= 1'b0;
        data_we  <= 1'b0;
    endtask

    task automatic mem_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] wdata);
        logic [31:0] ignored;
        data_access(addr, 1'b1, mask, wdata, 1'b0, ignored);
        mem_copy[addr[9:2]] = masked_merge(expected_mem(addr), wdata, mask);
        mem_set[addr[9:2]]  = 1'b1;
    endtask

    task automatic mem_check(input logic [31:0] addr);
        logic [31:0] got;
        data_access(addr, 1'b0, 4'hf, 32'h0, 1'b0, got);
        assert (got == expected_mem(addr))
            else report_mismatch($sformatf("read %h got %h want %h", addr, got,
                                           expected_mem(addr)));
    endtask

    // fetch miss and memory read launched at the same edge
    task automatic contend(input logic [31:0] fetch_a, input logic [31:0] mem_a);
        logic        fetch_ok;
        logic        data_ok;
        logic [31:0] got_instr;
        logic [31:0] got_data;
        int          cycles;
        @(posedge clk);
        fetch_addr <= fetch_a;
        data_sel   <= 1'b1;
        data_addr  <= mem_a;
        data_we    <= 1'b0;
        data_mask  <= 4'hf;
        fetch_ok = 1'b0;
        data_ok  = 1'b0;
        cycles   = 0;
        while (!(fetch_ok && data_ok)) begin
            @(negedge clk);
            if (!fetch_ok && !instr_wait) begin
                fetch_ok  = 1'b1;
                got_instr = instr;
            end
            if (!data_ok && !data_stall) begin
                data_ok  = 1'b1;
                got_data = data_rdata;
            end
            cycles++;
            if (cycles > timeout_cycles) give_up("fetch and data access never both finished");
            @(posedge clk);
            if (data_ok) data_sel <= 1'b0;
        end
        assert (got_instr == expected_fill(fetch_a))
            else report_mismatch($sformatf("contended fetch %h got %h", fetch_a, got_instr));
        assert (got_data == expected_mem(mem_a))
            else report_mismatch($sformatf("contended read %h got %h", mem_a, got_data));
    endtask

    task automatic timer_check();
        logic [31:0] first;
        logic [31:0] last;
        @(posedge clk);
        data_sel  <= 1'b1;
        data_addr <= 32'h1000_0000;
        data_we   <= 1'b0;
        @(negedge clk);
        first = data_rdata;
        assert (!data_stall) else report_mismatch("timer access stalled");
        repeat (timer_gap) @(negedge clk);
        last = data_rdata;
        assert (!data_stall) else report_mismatch("timer access stalled");
        assert ((last - first) == timer_gap)
            else report_mismatch($sformatf("timer moved %0d in %0d cycles", last - first,
                                           timer_gap));
        @(posedge clk);
        data_sel <= 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] off, input logic [3:0] mask,
                             input logic [31:0] wdata);
        logic [31:0] ignored;
        logic [31:0] merged;
        pwm_written <= 1'b1;
        data_access(32'h2000_0000 | 32'(off), 1'b1, mask, wdata, 1'b1, ignored);
        merged = masked_merge(expected_reg(off), wdata, mask);
        case (off)
            soc_mem_pkg::pwm_period_off: period_copy = merged[soc_mem_pkg::pwm_w-1:0];
            soc_mem_pkg::pwm_duty0_off:  duty0_copy  = merged[soc_mem_pkg::pwm_w-1:0];
            soc_mem_pkg::pwm_duty1_off:  duty1_copy  = merged[soc_mem_pkg::pwm_w-1:0];
            default: ;
        endcase
    endtask

    task automatic reg_check(input logic [3:0] off);
        logic [31:0] got;
        data_access(32'h2000_0000 | 32'(off), 1'b0, 4'hf, 32'h0, 1'b1, got);
        assert (got == expected_reg(off))
            else report_mismatch($sformatf("register %h got %h want %h", off, got,
                                           expected_reg(off)));
    endtask

    task automatic pwm_check(input logic [15:0] period, input logic [15:0] duty0,
                             input logic [15:0] duty1);
        int highs0;
        int highs1;
        highs0 = 0;
        highs1 = 0;
        reg_write(soc_mem_pkg::pwm_period_off, 4'b1111, 32'(period));
        reg_write(soc_mem_pkg::pwm_duty0_off, 4'b0011, 32'(duty0));
        reg_write(soc_mem_pkg::pwm_duty1_off, 4'b0011, 32'(duty1));
        repeat (int'(period) + 3) @(negedge clk); // counter settles on the new period
        for (int i = 0; i <= int'(period); i++) begin
            @(negedge clk);
            if (pwm0) highs0++;
            if (pwm1) highs1++;
        end
        assert (highs0 == int'(duty0))
            else report_mismatch($sformatf("pwm0 high %0d of %0d", highs0, period + 1));
        assert (highs1 == int'(duty1))
            else report_mismatch($sformatf("pwm1 high %0d of %0d", highs1, period + 1));
    endtask

    initial begin
        apply_reset();
        fetch_word(32'h0000_0000, 1'b0);
        fetch_word(32'h0000_0010, 1'b0);
        fetch_word(32'h0000_0024, 1'b0);
        fetch_word(32'h0000_0010, 1'b1);
        fetch_word(32'h0000_0050, 1'b0); // same index, new tag
        fetch_word(32'h0000_0010, 1'b0);
        mem_check(32'h4000_0100);
        mem_write(32'h4000_0100, 4'b1111, 32'hdead_beef);
        mem_check(32'h4000_0100);
        mem_write(32'h4000_0100, 4'b0010, 32'h0000_5500);
        mem_write(32'h4000_0100, 4'b1000, 32'h7700_0000);
        mem_check(32'h4000_0100);
        mem_write(32'h4000_0104, 4'b0101, 32'h1234_5678);
        mem_check(32'h4000_0104);
        contend(32'h0000_0080, 32'h4000_0104);
        contend(32'h0000_00c4, 32'h4000_0108);
        timer_check();
        reg_write(soc_mem_pkg::pwm_period_off, 4'b1111, 32'hffff_1234);
        reg_write(soc_mem_pkg::pwm_duty0_off, 4'b0001, 32'h0000_ab56);
        reg_write(soc_mem_pkg::pwm_duty0_off, 4'b0010, 32'h0000_0700);
        reg_write(soc_mem_pkg::pwm_duty1_off, 4'b1100, 32'h5a5a_5a5a);
        reg_write(4'hc, 4'b1111, 32'h0000_00ff);
        reg_check(soc_mem_pkg::pwm_period_off);
        reg_check(soc_mem_pkg::pwm_duty0_off);
        reg_check(soc_mem_pkg::pwm_duty1_off);
        reg_check(4'hc);
        pwm_check(16'd9, 16'd4, 16'd10);
        pwm_check(16'd5, 16'd0, 16'd3);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/soc_mem_pkg.sv
hdl/instr_cache.sv
hdl/mem_controller.sv
hdl/pwm_regs.sv
hdl/pwm_gen.sv
hdl/soc_mem_top.sv
dv/iomem_model.sv
dv/tb_soc_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_soc_mem \
    -f all.f \
    -Mdir obj_dir \
    -o sim_soc_mem

./obj_dir/sim_soc_mem
